// ==== flist.f ====
+incdir+test
hw/id_pkg.sv
hw/id_decoder.sv
hw/id_regfile.sv
hw/id_operand_sel.sv
hw/id_ex_reg.sv
hw/id_stage.sv
test/tb_id_stage.sv

// ==== hw/id_decoder.sv ====
`timescale 1ns/100ps

module id_decoder
	import id_pkg::*;
(
	input  logic [INST_W-1:0] inst_i,
	output dec_ctrl_t         ctrl_o
);

	op_e                   opcode;
	funct_e                funct;
	logic [REG_ADDR_W-1:0] rs;
	logic [REG_ADDR_W-1:0] rt;
	logic [REG_ADDR_W-1:0] rd;
	logic [REG_ADDR_W-1:0] shamt;
	logic [IMM_W-1:0]      imm16;

	aluop_e                fn_aluop;     // Operation of a SPECIAL instruction
	logic                  fn_shamt;     // Shift amount comes from the word
	logic                  fn_legal;
	aluop_e                op_aluop;     // Operation of an immediate instruction
	logic [DATA_W-1:0]     imm_ext;

	assign opcode = op_e'(inst_i[31:26]);
	assign rs     = inst_i[25:21];
	assign rt     = inst_i[20:16];
	assign rd     = inst_i[15:11];
	assign shamt  = inst_i[10:6];
	assign funct  = funct_e'(inst_i[5:0]);
	assign imm16  = inst_i[15:0];

	// Result class of each operation
	function automatic alusel_e sel_of(aluop_e op);
		case (op)
			ALU_AND, ALU_OR, ALU_XOR, ALU_NOR:
				return SEL_LOGIC;
			ALU_SLL, ALU_SRL, ALU_SRA:
				return SEL_SHIFT;
			ALU_MOVN, ALU_MOVZ:
				return SEL_MOVE;
			ALU_SLT, ALU_SLTU, ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU, ALU_ADDI, ALU_ADDIU:
				return SEL_ARITH;
			default:
				return SEL_NOP;
		endcase
	endfunction

	// ----------------------------------------------------------------------
	// Function code and opcode classification
	// ----------------------------------------------------------------------
	always_comb
	begin
		case (funct)
			FN_AND:  fn_aluop = ALU_AND;
			FN_OR:   fn_aluop = ALU_OR;
			FN_XOR:  fn_aluop = ALU_XOR;
			FN_NOR:  fn_aluop = ALU_NOR;
			FN_SLL:  fn_aluop = ALU_SLL;
			FN_SRL:  fn_aluop = ALU_SRL;
			FN_SRA:  fn_aluop = ALU_SRA;
			FN_SLLV: fn_aluop = ALU_SLL;  // Same op, amount from rs
			FN_SRLV: fn_aluop = ALU_SRL;
			FN_SRAV: fn_aluop = ALU_SRA;
			FN_MOVN: fn_aluop = ALU_MOVN;
			FN_MOVZ: fn_aluop = ALU_MOVZ;
			FN_SLT:  fn_aluop = ALU_SLT;
			FN_SLTU: fn_aluop = ALU_SLTU;
			FN_ADD:  fn_aluop = ALU_ADD;
			FN_ADDU: fn_aluop = ALU_ADDU;
			FN_SUB:  fn_aluop = ALU_SUB;
			FN_SUBU: fn_aluop = ALU_SUBU;
			default: fn_aluop = ALU_NOP;  // mult, mfhi, sync and the like
		endcase
	end

	assign fn_shamt = (funct == FN_SLL) || (funct == FN_SRL) || (funct == FN_SRA);

	// Constant shifts need rs zero, all others need shamt zero
	assign fn_legal = (fn_aluop != ALU_NOP) && (fn_shamt ? (rs == '0) : (shamt == '0));

	always_comb
	begin
		case (opcode)
			OP_ANDI:  op_aluop = ALU_AND;
			OP_ORI:   op_aluop = ALU_OR;
			OP_XORI:  op_aluop = ALU_XOR;
			OP_LUI:   op_aluop = ALU_OR;   // rs | (imm << 16)
			OP_SLTI:  op_aluop = ALU_SLT;
			OP_SLTIU: op_aluop = ALU_SLTU;
			OP_ADDI:  op_aluop = ALU_ADDI;
			OP_ADDIU: op_aluop = ALU_ADDIU;
			default:  op_aluop = ALU_NOP;
		endcase
	end

	always_comb
	begin
		case (opcode)
			OP_SPECIAL:
				imm_ext = {{(DATA_W-REG_ADDR_W){1'b0}}, shamt};
			OP_LUI:
				imm_ext = {imm16, {(DATA_W-IMM_W){1'b0}}};
			OP_SLTI, OP_SLTIU, OP_ADDI, OP_ADDIU:
				imm_ext = {{(DATA_W-IMM_W){imm16[IMM_W-1]}}, imm16};
			default:
				imm_ext = {{(DATA_W-IMM_W){1'b0}}, imm16};
		endcase
	end

	// ----------------------------------------------------------------------
	// Control word
	// ----------------------------------------------------------------------
	always_comb
	begin
		ctrl_o           = '0;
		ctrl_o.reg1_addr = rs;
		ctrl_o.reg2_addr = rt;
		ctrl_o.wd        = rd;              // Unknown encodings keep rd
		ctrl_o.aluop     = ALU_NOP;
		ctrl_o.alusel    = SEL_NOP;
		if (opcode == OP_SPECIAL)
		begin
			if (fn_legal)
			begin
				ctrl_o.reg1_read = !fn_shamt;  // Shamt replaces rs
				ctrl_o.reg2_read = 1'b1;
				ctrl_o.imm       = imm_ext;
				ctrl_o.aluop     = fn_aluop;
				ctrl_o.alusel    = sel_of(fn_aluop);
				ctrl_o.wreg      = 1'b1;       // movn/movz resolved later
			end
		end
		else if (op_aluop != ALU_NOP)
		begin
			ctrl_o.reg1_read = 1'b1;
			ctrl_o.imm       = imm_ext;        // Lands in operand 2
			ctrl_o.aluop     = op_aluop;
			ctrl_o.alusel    = sel_of(op_aluop);
			ctrl_o.wd        = rt;
			ctrl_o.wreg      = 1'b1;
		end
	end

endmodule

// ==== hw/id_ex_reg.sv ====
`timescale 1ns/100ps

module id_ex_reg
	import id_pkg::*;
(
	input  logic              clk_i,
	input  logic              rst_n_i,
	input  dec_ctrl_t         ctrl_i,
	input  logic [DATA_W-1:0] reg1_i,
	input  logic [DATA_W-1:0] reg2_i,
	output id_out_t           out_o
);

	logic wreg_d;

	// Conditional moves only write when rt meets the test
	always_comb
	begin
		case (ctrl_i.aluop)
			ALU_MOVN:
				wreg_d = ctrl_i.wreg && (reg2_i != '0);
			ALU_MOVZ:
				wreg_d = ctrl_i.wreg && (reg2_i == '0);
			default:
				wreg_d = ctrl_i.wreg;
		endcase
	end

	always_ff @(posedge clk_i)
	begin
		if (!rst_n_i)
		begin
			out_o.aluop  <= ALU_NOP;
			out_o.alusel <= SEL_NOP;
			out_o.reg1   <= '0;
			out_o.reg2   <= '0;
			out_o.wd     <= '0;
			out_o.wreg   <= 1'b0;
		end
		else
		begin
			out_o.aluop  <= ctrl_i.aluop;
			out_o.alusel <= ctrl_i.alusel;
			out_o.reg1   <= reg1_i;
			out_o.reg2   <= reg2_i;
			out_o.wd     <= ctrl_i.wd;
			out_o.wreg   <= wreg_d;
		end
	end

endmodule

// ==== hw/id_operand_sel.sv ====
`timescale 1ns/100ps

module id_operand_sel
	import id_pkg::*;
(
	input  logic                  read_i,     // Operand comes from a register
	input  logic [REG_ADDR_W-1:0] addr_i,
	input  logic [DATA_W-1:0]     rf_data_i,
	input  logic [DATA_W-1:0]     imm_i,
	input  reg_wr_t               ex_fwd_i,
	input  reg_wr_t               mem_fwd_i,
	output logic [DATA_W-1:0]     operand_o
);

	logic ex_hit;
	logic mem_hit;

	// r0 is matched too, the later stages never write it
	assign ex_hit  = ex_fwd_i.we && (ex_fwd_i.addr == addr_i);
	assign mem_hit = mem_fwd_i.we && (mem_fwd_i.addr == addr_i);

	always_comb
	begin
		if (!read_i)
			operand_o = imm_i;
		else if (ex_hit)
			operand_o = ex_fwd_i.data;      // Youngest result wins
		else if (mem_hit)
			operand_o = mem_fwd_i.data;
		else
			operand_o = rf_data_i;
	end

endmodule

// ==== hw/id_pkg.sv ====
package id_pkg;

	// ----------------------------------------------------------------------
	// Widths
	// ----------------------------------------------------------------------
	localparam int DATA_W     = 32;          // Data word
	localparam int INST_W     = 32;          // Instruction word
	localparam int REG_ADDR_W = 5;           // Register index
	localparam int REG_NUM    = 32;          // General purpose registers
	localparam int IMM_W      = 16;          // Raw immediate field

	// ----------------------------------------------------------------------
	// Instruction encodings
	// ----------------------------------------------------------------------
	typedef enum logic [5:0] {
		OP_SPECIAL = 6'b000000,              // Register-register group
		OP_ADDI    = 6'b001000,
		OP_ADDIU   = 6'b001001,
		OP_SLTI    = 6'b001010,
		OP_SLTIU   = 6'b001011,
		OP_ANDI    = 6'b001100,
		OP_ORI     = 6'b001101,
		OP_XORI    = 6'b001110,
		OP_LUI     = 6'b001111
	} op_e;

	typedef enum logic [5:0] {
		FN_SLL  = 6'b000000,                 // Shift by shamt
		FN_SRL  = 6'b000010,
		FN_SRA  = 6'b000011,
		FN_SLLV = 6'b000100,                 // Shift by rs
		FN_SRLV = 6'b000110,
		FN_SRAV = 6'b000111,
		FN_MOVZ = 6'b001010,
		FN_MOVN = 6'b001011,
		FN_ADD  = 6'b100000,
		FN_ADDU = 6'b100001,
		FN_SUB  = 6'b100010,
		FN_SUBU = 6'b100011,
		FN_AND  = 6'b100100,
		FN_OR   = 6'b100101,
		FN_XOR  = 6'b100110,
		FN_NOR  = 6'b100111,
		FN_SLT  = 6'b101010,
		FN_SLTU = 6'b101011
	} funct_e;

	// ----------------------------------------------------------------------
	// Execute operations
	// ----------------------------------------------------------------------
	typedef enum logic [7:0] {
		ALU_NOP   = 8'b00000000,
		ALU_SRL   = 8'b00000010,
		ALU_SRA   = 8'b00000011,
		ALU_MOVZ  = 8'b00001010,
		ALU_MOVN  = 8'b00001011,
		ALU_ADD   = 8'b00100000,
		ALU_ADDU  = 8'b00100001,
		ALU_SUB   = 8'b00100010,
		ALU_SUBU  = 8'b00100011,
		ALU_AND   = 8'b00100100,
		ALU_OR    = 8'b00100101,
		ALU_XOR   = 8'b00100110,
		ALU_NOR   = 8'b00100111,
		ALU_SLT   = 8'b00101010,
		ALU_SLTU  = 8'b00101011,
		ALU_ADDI  = 8'b01010101,
		ALU_ADDIU = 8'b01010110,
		ALU_SLL   = 8'b01111100
	} aluop_e;

	typedef enum logic [2:0] {
		SEL_NOP   = 3'b000,
		SEL_LOGIC = 3'b001,
		SEL_SHIFT = 3'b010,
		SEL_MOVE  = 3'b011,
		SEL_ARITH = 3'b100
	} alusel_e;

	// ----------------------------------------------------------------------
	// Stage structs
	// ----------------------------------------------------------------------
	typedef struct packed {
		logic                  we;           // Write enable
		logic [REG_ADDR_W-1:0] addr;         // Destination register
		logic [DATA_W-1:0]     data;         // Write value
	} reg_wr_t;

	typedef struct packed {
		logic                  reg1_read;    // Operand 1 from a register
		logic                  reg2_read;    // Operand 2 from a register
		logic [REG_ADDR_W-1:0] reg1_addr;    // rs
		logic [REG_ADDR_W-1:0] reg2_addr;    // rt
		logic [DATA_W-1:0]     imm;          // Extended immediate
		aluop_e                aluop;
		alusel_e               alusel;
		logic [REG_ADDR_W-1:0] wd;           // Destination register
		logic                  wreg;         // Tentative write
	} dec_ctrl_t;

	typedef struct packed {
		aluop_e                aluop;
		alusel_e               alusel;
		logic [DATA_W-1:0]     reg1;         // Source operand 1
		logic [DATA_W-1:0]     reg2;         // Source operand 2
		logic [REG_ADDR_W-1:0] wd;
		logic                  wreg;
	} id_out_t;

endpackage

// ==== hw/id_regfile.sv ====
`timescale 1ns/100ps

module id_regfile
	import id_pkg::*;
(
	input  logic                  clk_i,
	input  logic                  rst_n_i,
	input  logic [REG_ADDR_W-1:0] raddr1_i,
	input  logic [REG_ADDR_W-1:0] raddr2_i,
	input  reg_wr_t               wr_i,
	output logic [DATA_W-1:0]     rdata1_o,
	output logic [DATA_W-1:0]     rdata2_o
);

	logic [DATA_W-1:0] regs [REG_NUM];

	always_ff @(posedge clk_i)
	begin
		if (!rst_n_i)
		begin
			for (int i = 0; i < REG_NUM; i++)
				regs[i] <= '0;
		end
		else if (wr_i.we && (wr_i.addr != '0))
			regs[wr_i.addr] <= wr_i.data;
	end

	// One read port with write-through from the write port
	function automatic logic [DATA_W-1:0] read_port(logic [REG_ADDR_W-1:0] addr);
		if (addr == '0)
			return '0;                     // r0 is hard-wired
		else if (wr_i.we && (wr_i.addr == addr))
			return wr_i.data;
		else
			return regs[addr];
	endfunction

	always_comb
	begin
		rdata1_o = read_port(raddr1_i);
		rdata2_o = read_port(raddr2_i);
	end

endmodule

// ==== hw/id_stage.sv ====
`timescale 1ns/100ps

module id_stage
	import id_pkg::*;
(
	input  logic              clk_i,
	input  logic              rst_n_i,
	input  logic [INST_W-1:0] inst_i,
	input  reg_wr_t           ex_fwd_i,    // Result in execute
	input  reg_wr_t           mem_fwd_i,   // Result in memory access
	input  reg_wr_t           wb_i,        // Register file write
	output id_out_t           id_out_o
);

	dec_ctrl_t         ctrl;
	logic [DATA_W-1:0] rf_data1;
	logic [DATA_W-1:0] rf_data2;
	logic [DATA_W-1:0] reg1;
	logic [DATA_W-1:0] reg2;

	id_decoder decoder_i (
		.inst_i (inst_i),
		.ctrl_o (ctrl)
	);

	id_regfile regfile_i (
		.clk_i    (clk_i),
		.rst_n_i  (rst_n_i),
		.raddr1_i (ctrl.reg1_addr),
		.raddr2_i (ctrl.reg2_addr),
		.wr_i     (wb_i),
		.rdata1_o (rf_data1),
		.rdata2_o (rf_data2)
	);

	// ----------------------------------------------------------------------
	// Operand selection, rs side and rt side
	// ----------------------------------------------------------------------
	id_operand_sel operand1_sel_i (
		.read_i    (ctrl.reg1_read),
		.addr_i    (ctrl.reg1_addr),
		.rf_data_i (rf_data1),
		.imm_i     (ctrl.imm),
		.ex_fwd_i  (ex_fwd_i),
		.mem_fwd_i (mem_fwd_i),
		.operand_o (reg1)
	);

	id_operand_sel operand2_sel_i (
		.read_i    (ctrl.reg2_read),
		.addr_i    (ctrl.reg2_addr),
		.rf_data_i (rf_data2),
		.imm_i     (ctrl.imm),
		.ex_fwd_i  (ex_fwd_i),
		.mem_fwd_i (mem_fwd_i),
		.operand_o (reg2)
	);

	id_ex_reg ex_reg_i (
		.clk_i   (clk_i),
		.rst_n_i (rst_n_i),
		.ctrl_i  (ctrl),
		.reg1_i  (reg1),
		.reg2_i  (reg2),
		.out_o   (id_out_o)
	);

endmodule

// ==== test/tb_id_util.svh ====
`ifndef TB_ID_UTIL_SVH
`define TB_ID_UTIL_SVH

// Register-register word, shamt only for constant shifts
function automatic logic [31:0] enc_r(input logic [5:0] fn, input logic [4:0] rs,
	input logic [4:0] rt, input logic [4:0] rd, input logic [4:0] sa);
	return {6'b000000, rs, rt, rd, sa, fn};
endfunction

function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs,
	input logic [4:0] rt, input logic [15:0] imm);
	return {op, rs, rt, imm};
endfunction

// Fibonacci LFSR with taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// One LFSR step per bit taken
function automatic logic [31:0] rand_bits(input int n);
	logic [31:0] v;
	v = '0;
	for (int k = 0; k < n; k++)
	begin
		v    = {v[30:0], lfsr[31]};
		lfsr = lfsr_next(lfsr);
	end
	return v;
endfunction

// Operand 2 of the immediate forms
function automatic logic [31:0] imm_ext(input op_e op, input logic [15:0] imm);
	case (op)
		OP_ANDI, OP_ORI, OP_XORI:
			return {16'h0000, imm};
		OP_LUI:
			return {imm, 16'h0000};
		default:
			return {{16{imm[15]}}, imm};     // slti, sltiu, addi, addiu
	endcase
endfunction

// Source value seen by decode, execute forward first
function automatic logic [31:0] reg_value(input logic [4:0] addr);
	if (ex_fwd_i.we && (ex_fwd_i.addr == addr))
		return ex_fwd_i.data;
	if (mem_fwd_i.we && (mem_fwd_i.addr == addr))
		return mem_fwd_i.data;
	if (addr == 5'd0)
		return '0;
	if (wb_i.we && (wb_i.addr == addr))
		return wb_i.data;                 // Same-cycle write
	return model_regs[addr];
endfunction

function automatic logic move_writes(input aluop_e op, input logic [31:0] rt_val);
	return (op == ALU_MOVN) ? (rt_val != '0) : (rt_val == '0);
endfunction

function automatic id_out_t make_out(input aluop_e op, input alusel_e sel,
	input logic [31:0] r1, input logic [31:0] r2, input logic [4:0] wd, input logic wreg);
	id_out_t o;
	o.aluop  = op;
	o.alusel = sel;
	o.reg1   = r1;
	o.reg2   = r2;
	o.wd     = wd;
	o.wreg   = wreg;
	return o;
endfunction

`endif

// ==== test/tb_id_stage.sv ====
`timescale 1ns/100ps

module tb_id_stage
	import id_pkg::*;
();

	localparam int CLK_PERIOD  = 20;
	localparam int WATCHDOG_NS = 20000;

	logic              clk_i;
	logic              rst_n_i;
	logic [INST_W-1:0] inst_i;
	reg_wr_t           ex_fwd_i;
	reg_wr_t           mem_fwd_i;
	reg_wr_t           wb_i;
	id_out_t           id_out_o;

	logic [DATA_W-1:0] model_regs [REG_NUM];  // Expected register contents
	logic [31:0]       lfsr = 32'h82aa;
	int                errors;
	int                test_errs;
	int                tests_run;
	int                tests_failed;
	string             test_name;

	logic [5:0] rr_fn  [13] = '{FN_AND, FN_OR, FN_XOR, FN_NOR, FN_ADD, FN_ADDU, FN_SUB,
		FN_SUBU, FN_SLT, FN_SLTU, FN_SLLV, FN_SRLV, FN_SRAV};
	aluop_e     rr_alu [13] = '{ALU_AND, ALU_OR, ALU_XOR, ALU_NOR, ALU_ADD, ALU_ADDU, ALU_SUB,
		ALU_SUBU, ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA};
	op_e        im_op  [8]  = '{OP_ANDI, OP_ORI, OP_XORI, OP_LUI, OP_SLTI, OP_SLTIU, OP_ADDI,
		OP_ADDIU};
	aluop_e     im_alu [8]  = '{ALU_AND, ALU_OR, ALU_XOR, ALU_OR, ALU_SLT, ALU_SLTU, ALU_ADDI,
		ALU_ADDIU};
	logic [5:0] sh_fn  [3]  = '{FN_SLL, FN_SRL, FN_SRA};
	aluop_e     sh_alu [3]  = '{ALU_SLL, ALU_SRL, ALU_SRA};

	`include "tb_id_util.svh"

	id_stage id_stage_i (
		.clk_i     (clk_i),
		.rst_n_i   (rst_n_i),
		.inst_i    (inst_i),
		.ex_fwd_i  (ex_fwd_i),
		.mem_fwd_i (mem_fwd_i),
		.wb_i      (wb_i),
		.id_out_o  (id_out_o)
	);

	initial
	begin
		clk_i = 1'b0;
		forever #(CLK_PERIOD/2) clk_i = ~clk_i;
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("Simulation ran past its time limit");
		$display("Test FAILED");
		$finish;
	end

	// ----------------------------------------------------------------------
	// Helpers
	// ----------------------------------------------------------------------
	task automatic next_negedge();
		int edges;
		edges = 0;
		while ((clk_i !== 1'b1) && (edges < 4))  // High phase first
		begin
			@(clk_i);
			edges++;
		end
		while ((clk_i !== 1'b0) && (edges < 4))
		begin
			@(clk_i);
			edges++;
		end
		if (clk_i !== 1'b0)
		begin
			$display("Clock did not fall within %0d edges", edges);
			errors++;
		end
	endtask

	task automatic check_field(input string sig, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp)
		else
		begin
			$display("FAILED %s got 0x%h exp 0x%h in %s", sig, got, exp, test_name);
			errors++;
		end
	endtask

	task automatic check_out(input id_out_t exp, input bit full);
		check_field("id_out_o.aluop", id_out_o.aluop, exp.aluop);
		check_field("id_out_o.alusel", id_out_o.alusel, exp.alusel);
		check_field("id_out_o.wd", id_out_o.wd, exp.wd);
		check_field("id_out_o.wreg", id_out_o.wreg, exp.wreg);
		if (full)
		begin
			check_field("id_out_o.reg1", id_out_o.reg1, exp.reg1);
			check_field("id_out_o.reg2", id_out_o.reg2, exp.reg2);
		end
	endtask

	// Output register takes the word on the next rising edge
	task automatic run_inst(input logic [31:0] inst, input id_out_t exp, input bit full);
		inst_i = inst;
		next_negedge();
		if (wb_i.we && (wb_i.addr != 5'd0))
			model_regs[wb_i.addr] = wb_i.data;
		ex_fwd_i  = '0;
		mem_fwd_i = '0;
		wb_i      = '0;
		check_out(exp, full);
	endtask

	task automatic write_reg(input logic [4:0] addr, input logic [31:0] data);
		wb_i = {1'b1, addr, data};
		next_negedge();
		if (addr != 5'd0)
			model_regs[addr] = data;          // r0 stays zero
		wb_i = '0;
	endtask

	task automatic test_begin(input string name);
		test_name = name;
		test_errs = errors;
	endtask

	task automatic test_end();
		tests_run++;
		if (errors == test_errs)
			$display("%-18s passed", test_name);
		else
		begin
			tests_failed++;
			$display("%-18s failed with %0d errors", test_name, errors - test_errs);
		end
	endtask

	// ----------------------------------------------------------------------
	// Stimulus
	// ----------------------------------------------------------------------
	initial
	begin
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [4:0]  rd;
		logic [15:0] imm;
		logic [31:0] data;
		aluop_e      op;
		id_out_t     exp;
		errors       = 0;
		tests_run    = 0;
		tests_failed = 0;
		rst_n_i      = 1'b0;
		inst_i       = '0;
		ex_fwd_i     = '0;
		mem_fwd_i    = '0;
		wb_i         = '0;
		for (int i = 0; i < REG_NUM; i++)
			model_regs[i] = '0;
		repeat (5) next_negedge();
		rst_n_i = 1'b1;

		test_begin("reset");
		check_out(make_out(ALU_NOP, SEL_NOP, '0, '0, 5'd0, 1'b0), 1'b1);
		exp = make_out(ALU_ADD, SEL_ARITH, '0, '0, 5'd7, 1'b1);
		run_inst(enc_r(FN_ADD, 5'd5, 5'd9, 5'd7, 5'd0), exp, 1'b1);
		test_end();

		test_begin("register-register");
		for (int a = 0; a < REG_NUM; a++)
			write_reg(5'(a), rand_bits(32));
		for (int i = 0; i < 13; i++)
		begin
			rs  = (i == 0) ? 5'd0 : 5'(rand_bits(5));  // First one reads r0
			rt  = 5'(rand_bits(5));
			rd  = 5'(rand_bits(5));
			exp = make_out(rr_alu[i], alusel_e'((i < 4) ? SEL_LOGIC :
				(i < 10) ? SEL_ARITH : SEL_SHIFT), reg_value(rs), reg_value(rt), rd, 1'b1);
			run_inst(enc_r(rr_fn[i], rs, rt, rd, 5'd0), exp, 1'b1);
		end
		test_end();

		test_begin("immediate");
		for (int i = 0; i < 8; i++)
		begin
			rs  = 5'(rand_bits(5));
			rt  = 5'(rand_bits(5));
			imm = 16'(rand_bits(16)) | {i[0], 15'd0};  // Odd ones negative
			exp = make_out(im_alu[i], alusel_e'((i < 4) ? SEL_LOGIC : SEL_ARITH),
				reg_value(rs), imm_ext(im_op[i], imm), rt, 1'b1);
			run_inst(enc_i(im_op[i], rs, rt, imm), exp, 1'b1);
		end
		for (int i = 0; i < 3; i++)
		begin
			rt  = 5'(rand_bits(5));
			rd  = 5'(rand_bits(5));
			rs  = 5'(rand_bits(5));                     // Used as shift amount
			exp = make_out(sh_alu[i], SEL_SHIFT, {27'd0, rs}, reg_value(rt), rd, 1'b1);
			run_inst(enc_r(sh_fn[i], 5'd0, rt, rd, rs), exp, 1'b1);
		end
		test_end();

		test_begin("forwarding");
		data = rand_bits(32);
		for (int k = 0; k < 5; k++)
		begin
			if (k == 0)
				ex_fwd_i = {1'b1, 5'd4, data};       // Both forwards on rs
			if (k < 2)
				mem_fwd_i = {1'b1, 5'd4, ~data};
			if (k == 1)
				ex_fwd_i = {1'b1, 5'd6, data ^ 32'h5a5a_a5a5};
			if (k == 3)
				wb_i = {1'b1, 5'd4, data + 32'd1};    // Write-through
			exp = make_out(ALU_ADD, SEL_ARITH, reg_value(5'd4), reg_value(5'd6), 5'd8, 1'b1);
			run_inst(enc_r(FN_ADD, 5'd4, 5'd6, 5'd8, 5'd0), exp, 1'b1);
		end
		test_end();

		test_begin("conditional move");
		write_reg(5'd10, '0);
		write_reg(5'd11, rand_bits(32) | 32'h1);
		for (int k = 0; k < 8; k++)
		begin
			rt = ((k[1:0] == 2'd1) || (k[1:0] == 2'd2)) ? 5'd11 : 5'd10;
			if (k[1:0] == 2'd2)
				ex_fwd_i = {1'b1, 5'd11, 32'h0};
			if (k[1:0] == 2'd3)
				mem_fwd_i = {1'b1, 5'd10, 32'h8000_0000};
			op  = aluop_e'(k[2] ? ALU_MOVZ : ALU_MOVN);
			exp = make_out(op, SEL_MOVE, reg_value(5'd3), reg_value(rt), 5'd12,
				move_writes(op, reg_value(rt)));
			run_inst(enc_r(k[2] ? FN_MOVZ : FN_MOVN, 5'd3, rt, 5'd12, 5'd0), exp, 1'b1);
		end
		test_end();

		test_begin("unknown");
		rd  = 5'd13;
		exp = make_out(ALU_NOP, SEL_NOP, '0, '0, rd, 1'b0);
		run_inst(enc_i(6'h3f, 5'd1, 5'd2, {rd, 11'd0}), exp, 1'b0);  // Unassigned opcode
		run_inst(enc_r(6'h18, 5'd1, 5'd2, rd, 5'd0), exp, 1'b0);      // mult
		run_inst(enc_r(6'h10, 5'd0, 5'd0, rd, 5'd0), exp, 1'b0);      // mfhi
		run_inst({6'h1c, 5'd1, 5'd1, rd, 5'd0, 6'h20}, exp, 1'b0);    // clz
		test_end();

		$display("Tests run %0d, failed %0d, failed checks %0d", tests_run, tests_failed,
			errors);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule
